// File: filelist.f
+incdir+.
b2s_pkg.sv
b2s_wr_cmd_fsm.sv
b2s_incr_cmd.sv
b2s_b_channel.sv
b2s_wr_top.sv
b2s_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the converter testbench, pass is decided from the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module b2s_tb -o b2s_sim \
  && ./obj_dir/b2s_sim | tee /dev/stderr | grep -qF "Regression passed" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: b2s_tb.sv
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_tb;

  import b2s_pkg::*;

  localparam int    NUM_ROWS = 8;
  localparam int    DEPTH    = `B2S_BFIFO_DEPTH;
  localparam resp_t OKAY     = 2'b00;
  localparam resp_t SLVERR   = 2'b10;

  // ========================================
  // burst table
  // ========================================

  // err is the beat index answered with slverr or -1 for an all okay burst.
  addr_t row_addr [NUM_ROWS] = '{32'h0000_1000, 32'h0000_2004, 32'h0001_0010, 32'h0000_0ff0,
                                 32'h8000_0100, 32'h0000_3000, 32'h0000_4040, 32'h1234_5670};
  len_t  row_len  [NUM_ROWS] = '{8'd0, 8'd3, 8'd7, 8'd1, 8'd2, 8'd15, 8'd0, 8'd4};
  id_t   row_id   [NUM_ROWS] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8};
  int    row_err  [NUM_ROWS] = '{-1, -1, 5, 0, -1, 15, 0, -1};

  logic  clk       = 1'b0;
  logic  reset     = 1'b1;
  logic  s_awvalid = 1'b0;
  logic  s_awready;
  addr_t s_awaddr  = '0;
  len_t  s_awlen   = '0;
  id_t   s_awid    = '0;
  logic  s_bvalid;
  logic  s_bready  = 1'b0;
  id_t   s_bid;
  resp_t s_bresp;
  logic  m_awvalid;
  logic  m_awready = 1'b0;
  addr_t m_awaddr;
  logic  m_bvalid  = 1'b0;
  logic  m_bready;
  resp_t m_bresp   = '0;

  integer      seed   = 32'h89968840;
  logic [31:0] rnd;
  logic        hold_b = 1'b0;

  // expected master commands with their beat resp, and expected slave responses.
  addr_t exp_addr[$];
  resp_t exp_beat_resp[$];
  resp_t b_pending[$];
  id_t   exp_id[$];
  resp_t exp_resp[$];

  always #4 clk = ~clk;

  b2s_wr_top i_b2s_wr_top (
    .clk       (clk),
    .reset     (reset),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_awaddr  (s_awaddr),
    .s_awlen   (s_awlen),
    .s_awid    (s_awid),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_bid     (s_bid),
    .s_bresp   (s_bresp),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_awaddr  (m_awaddr),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .m_bresp   (m_bresp)
  );

  // ========================================
  // failure reporting and compares
  // ========================================

  task automatic halt_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    halt_run();
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      halt_run();
    end
  endtask

  // ========================================
  // master side model and slave b monitor
  // ========================================

  // master aw and b responder, which also paces s_bready.
  always @(posedge clk) begin
    rnd = $random(seed);
    if (reset) begin
      m_awready <= 1'b0;
      m_bvalid  <= 1'b0;
      s_bready  <= 1'b0;
    end else begin
      m_awready <= rnd[0];
      s_bready  <= !hold_b && (rnd[2:1] != 2'b00);
      if (m_awvalid && m_awready) begin
        if (exp_addr.size() == 0) begin
          report_error("master command issued with no burst expecting it");
        end else begin
          check_addr("m_awaddr", m_awaddr, exp_addr.pop_front());
          b_pending.push_back(exp_beat_resp.pop_front());
        end
      end
      if (!m_bvalid || m_bready) begin
        if ((b_pending.size() != 0) && rnd[3]) begin
          m_bvalid <= 1'b1;
          m_bresp  <= b_pending.pop_front();
        end else begin
          m_bvalid <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && s_bvalid && s_bready) begin
      if (exp_id.size() == 0) begin
        report_error("slave response returned with no burst outstanding");
      end else begin
        check_id("s_bid", s_bid, exp_id.pop_front());
        check_resp("s_bresp", s_bresp, exp_resp.pop_front());
      end
    end
  end

  // ========================================
  // slave aw driver
  // ========================================

  task automatic start_burst(input int r);
    int i;
    for (i = 0; i <= int'(row_len[r]); i++) begin
      exp_addr.push_back(row_addr[r] + addr_t'(i * `B2S_BEAT_BYTES));
      exp_beat_resp.push_back((i == row_err[r]) ? SLVERR : OKAY);
    end
    exp_id.push_back(row_id[r]);
    exp_resp.push_back((row_err[r] >= 0) ? SLVERR : OKAY);
    @(posedge clk);
    s_awvalid <= 1'b1;
    s_awaddr  <= row_addr[r];
    s_awlen   <= row_len[r];
    s_awid    <= row_id[r];
  endtask

  task automatic wait_awready();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!s_awready) begin
      if (cycles == 500) begin
        report_error("timeout waiting for s_awready");
      end
      cycles++;
      @(posedge clk);
    end
    s_awvalid <= 1'b0;
  endtask

  task automatic wait_cmds_sent();
    int cycles;
    cycles = 0;
    while (exp_addr.size() != 0) begin
      if (cycles == 500) begin
        report_error("timeout waiting for the master commands of a burst");
      end
      cycles++;
      @(posedge clk);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_addr.size() != 0) || (b_pending.size() != 0) || (exp_id.size() != 0)) begin
      if (cycles == 3000) begin
        report_error("timeout waiting for all responses to return");
      end
      cycles++;
      @(posedge clk);
    end
  endtask

  initial begin
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    // outputs stay quiet while nothing is offered.
    repeat (10) begin
      @(posedge clk);
      if (m_awvalid || s_awready || s_bvalid || m_bready) begin
        report_error("handshake output raised before any stimulus");
      end
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      start_burst(r);
      wait_awready();
    end
    wait_drain();
    // fill the response fifo and offer one more burst.
    hold_b <= 1'b1;
    for (int r = 0; r < DEPTH; r++) begin
      start_burst(r);
      wait_awready();
    end
    start_burst(DEPTH);
    wait_cmds_sent();
    repeat (20) begin
      @(posedge clk);
      if (s_awready) begin
        report_error("s_awready raised while the response FIFO was full");
      end
    end
    hold_b <= 1'b0;
    wait_awready();
    for (int r = DEPTH + 1; r < NUM_ROWS; r++) begin
      start_burst(r);
      wait_awready();
    end
    wait_drain();
    repeat (20) @(posedge clk);
    if (m_awvalid || s_bvalid) begin
      report_error("commands or responses left over at the end of the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: b2s_wr_top.sv
`timescale 1ns/1ps

module b2s_wr_top (
  input  logic           clk,
  input  logic           reset,
  // slave aw.
  input  logic           s_awvalid,
  output logic           s_awready,
  input  b2s_pkg::addr_t s_awaddr,
  input  b2s_pkg::len_t  s_awlen,
  input  b2s_pkg::id_t   s_awid,
  // slave b.
  output logic           s_bvalid,
  input  logic           s_bready,
  output b2s_pkg::id_t   s_bid,
  output b2s_pkg::resp_t s_bresp,
  // master aw, single beat.
  output logic           m_awvalid,
  input  logic           m_awready,
  output b2s_pkg::addr_t m_awaddr,
  // master b.
  input  logic           m_bvalid,
  output logic           m_bready,
  input  b2s_pkg::resp_t m_bresp
);

  logic a_push;
  logic next;
  logic next_pending;
  logic b_push;
  logic b_full;

  b2s_wr_cmd_fsm i_cmd_fsm (
    .clk          (clk),
    .reset        (reset),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .m_awvalid    (m_awvalid),
    .m_awready    (m_awready),
    .next         (next),
    .next_pending (next_pending),
    .b_push       (b_push),
    .b_full       (b_full),
    .a_push       (a_push)
  );

  b2s_incr_cmd i_incr_cmd (
    .clk          (clk),
    .reset        (reset),
    .a_push       (a_push),
    .next         (next),
    .s_awaddr     (s_awaddr),
    .s_awlen      (s_awlen),
    .m_awaddr     (m_awaddr),
    .next_pending (next_pending)
  );

  b2s_b_channel i_b_channel (
    .clk      (clk),
    .reset    (reset),
    .b_push   (b_push),
    .s_awlen  (s_awlen),
    .s_awid   (s_awid),
    .b_full   (b_full),
    .m_bvalid (m_bvalid),
    .m_bready (m_bready),
    .m_bresp  (m_bresp),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .s_bid    (s_bid),
    .s_bresp  (s_bresp)
  );

endmodule

// File: b2s_b_channel.sv
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_b_channel (
  input  logic           clk,
  input  logic           reset,
  input  logic           b_push,
  input  b2s_pkg::len_t  s_awlen,
  input  b2s_pkg::id_t   s_awid,
  output logic           b_full,
  input  logic           m_bvalid,
  output logic           m_bready,
  input  b2s_pkg::resp_t m_bresp,
  output logic           s_bvalid,
  input  logic           s_bready,
  output b2s_pkg::id_t   s_bid,
  output b2s_pkg::resp_t s_bresp
);

  import b2s_pkg::*;

  localparam int DEPTH = `B2S_BFIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  cnt_t             fifo_cnt [DEPTH];
  id_t              fifo_id  [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fill;
  logic             empty;
  logic             beat;
  logic             pop;
  cnt_t             beat_cnt;
  cnt_t             beat_cnt_nxt;
  resp_t            merged;
  logic             bvalid_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ========================================
  // burst record fifo
  // ========================================

  always_ff @(posedge clk) begin
    if (b_push) begin
      fifo_cnt[wr_ptr] <= cnt_t'(s_awlen) + cnt_t'(1);
      fifo_id[wr_ptr]  <= s_awid;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (b_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (b_push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !b_push) begin
        fill <= fill - 1'b1;
      end
    end
  end

  assign empty  = (fill == '0);
  assign b_full = (fill == (PTR_W + 1)'(DEPTH));

  // ========================================
  // beat count and merge
  // ========================================

  assign m_bready     = !empty && !bvalid_q;
  assign beat         = m_bvalid && m_bready;
  assign pop          = bvalid_q && s_bready;
  assign beat_cnt_nxt = beat_cnt + cnt_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
      merged   <= '0;
      bvalid_q <= 1'b0;
    end else begin
      if (beat) begin
        // worst code wins.
        merged <= (m_bresp > merged) ? m_bresp : merged;
        if (beat_cnt_nxt == fifo_cnt[rd_ptr]) begin
          beat_cnt <= '0;
          bvalid_q <= 1'b1;
        end else begin
          beat_cnt <= beat_cnt_nxt;
        end
      end
      if (pop) begin
        bvalid_q <= 1'b0;
        merged   <= '0;
      end
    end
  end

  assign s_bvalid = bvalid_q;
  assign s_bid    = fifo_id[rd_ptr];
  assign s_bresp  = merged;

  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    b_push |-> !b_full);

endmodule

// File: b2s_incr_cmd.sv
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_incr_cmd (
  input  logic           clk,
  input  logic           reset,
  input  logic           a_push,
  input  logic           next,
  input  b2s_pkg::addr_t s_awaddr,
  input  b2s_pkg::len_t  s_awlen,
  output b2s_pkg::addr_t m_awaddr,
  output logic           next_pending
);

  import b2s_pkg::*;

  addr_t addr_q;
  // beats left after the one on m_aw.
  cnt_t  remain_q;

  // ========================================
  // address
  // ========================================

  always_ff @(posedge clk) begin
    if (a_push) begin
      addr_q <= s_awaddr;
    end else if (next) begin
      addr_q <= addr_q + addr_t'(`B2S_BEAT_BYTES);
    end
  end

  // ========================================
  // remaining beats
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      remain_q <= '0;
    end else if (a_push) begin
      remain_q <= cnt_t'(s_awlen);
    end else if (next && (remain_q != '0)) begin
      // the step at burst end finds zero and leaves it.
      remain_q <= remain_q - cnt_t'(1);
    end
  end

  assign m_awaddr     = addr_q;
  assign next_pending = (remain_q != '0);

  // loading and stepping belong to different fsm states.
  a_next_not_load: assert property (@(posedge clk) disable iff (reset)
    next |-> !a_push);

endmodule

// File: b2s_wr_cmd_fsm.sv
`timescale 1ns/1ps

module b2s_wr_cmd_fsm (
  input  logic clk,
  input  logic reset,
  input  logic s_awvalid,
  output logic s_awready,
  output logic m_awvalid,
  input  logic m_awready,
  output logic next,
  input  logic next_pending,
  output logic b_push,
  input  logic b_full,
  output logic a_push
);

  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    CMD_EN       = 2'b01,
    CMD_ACCEPTED = 2'b10,
    DONE_WAIT    = 2'b11
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   burst_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (s_awvalid) begin
          state_nxt = CMD_EN;
        end
      end
      CMD_EN: begin
        if (m_awready && next_pending) begin
          state_nxt = CMD_ACCEPTED;
        end else if (m_awready && b_full) begin
          state_nxt = DONE_WAIT;
        end else if (m_awready) begin
          state_nxt = IDLE;
        end
      end
      // one gap cycle while the incrementer steps.
      CMD_ACCEPTED: state_nxt = CMD_EN;
      DONE_WAIT: begin
        if (!b_full) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // last command gone and room for the response record.
  assign burst_done = ((state == CMD_EN) || (state == DONE_WAIT)) && (state_nxt == IDLE);

  assign m_awvalid = (state == CMD_EN);
  assign next      = (state == CMD_ACCEPTED) || burst_done;
  assign a_push    = (state == IDLE);
  assign s_awready = burst_done;
  assign b_push    = burst_done;

  // the burst request stays up until its acknowledge.
  a_s_awvalid_hold: assert property (@(posedge clk) disable iff (reset)
    s_awvalid && !s_awready |=> s_awvalid);

endmodule

// File: b2s_pkg.sv
`include "b2s_params.svh"

package b2s_pkg;

  // ========================================
  // shared vector types
  // ========================================

  // byte address of a beat.
  typedef logic [`B2S_ADDR_W-1:0] addr_t;

  // transaction id returned unchanged on b.
  typedef logic [`B2S_ID_W-1:0] id_t;

  // raw awlen field.
  typedef logic [`B2S_LEN_W-1:0] len_t;

  // beat count one bit wider than len so 256 fits.
  typedef logic [`B2S_LEN_W:0] cnt_t;

  // okay, exokay, slverr, decerr.
  typedef logic [1:0] resp_t;

endpackage

// File: b2s_params.svh
`ifndef B2S_PARAMS_SVH
`define B2S_PARAMS_SVH

// ========================================
// converter widths
// ========================================

// byte address.
`define B2S_ADDR_W 32
// axi id.
`define B2S_ID_W 4
// burst length field holding the beat count minus one.
`define B2S_LEN_W 8

// ========================================
// beat size and response depth
// ========================================

`define B2S_BEAT_BYTES 4
// bursts with responses still outstanding.
`define B2S_BFIFO_DEPTH 4

`endif
